// ==== common/cpu_types_pkg.sv ====
package cpu_types_pkg;

    // Datapath and address widths
    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int CSR_ADDR_W = 14;
    localparam int ALUSEL_W   = 3;
    localparam int ALUOP_W    = 8;
    localparam int EXCP_NUM_W = 6;

    // Pipeline geometry
    localparam int ISSUE_WIDTH   = 2;
    localparam int EXE_FWD_PORTS = 2;
    localparam int MEM_FWD_PORTS = 2;
    localparam int NUM_REGS      = 32;
    localparam int RF_RD_PORTS   = 2 * ISSUE_WIDTH;
    localparam int RF_WR_PORTS   = 2;
    localparam int CSR_DEPTH     = 16;
    localparam int CSR_IDX_W     = $clog2(CSR_DEPTH);
    localparam int BR_FLAGS_W    = 6;

    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
    typedef logic [ALUSEL_W-1:0]   alusel_t;
    typedef logic [ALUOP_W-1:0]    aluop_t;
    typedef logic [EXCP_NUM_W-1:0] excp_num_t;

    // Result classes
    localparam alusel_t RES_NOP        = 3'b000;
    localparam alusel_t RES_LOGIC      = 3'b001;
    localparam alusel_t RES_ARITH      = 3'b011;
    localparam alusel_t RES_LOAD_STORE = 3'b100;
    localparam alusel_t RES_BRANCH     = 3'b101;
    localparam alusel_t RES_CSR        = 3'b110;

    // CSR instructions carry their CSR number in the low immediate bits
    typedef struct packed {
        logic [DATA_W-CSR_ADDR_W-1:0] unused;
        csr_addr_t                    addr;
    } imm_csr_t;

    typedef union packed {
        data_t    value;
        imm_csr_t csr;
    } imm_u;

endpackage

// ==== common/pipe_if_pkg.sv ====
package pipe_if_pkg;

    import cpu_types_pkg::*;

    typedef struct packed {
        logic  valid;
        data_t pc;
    } instr_info_t;

    // Decoded instruction from the decode stage
    typedef struct packed {
        instr_info_t     instr_info;
        aluop_t          aluop;
        alusel_t         alusel;
        logic      [1:0] reg_read_valid;
        reg_addr_t [1:0] reg_read_addr;
        logic            reg_write_valid;
        reg_addr_t       reg_write_addr;
        logic            use_imm;
        imm_u            imm;
        logic            csr_we;
        logic            excp;
        excp_num_t       excp_num;
        logic            refetch;
    } id_dispatch_t;

    // One forwarding source from EXE or MEM
    typedef struct packed {
        logic      valid;
        reg_addr_t addr;
        data_t     data;
    } fwd_t;

    // Record handed to EXE
    typedef struct packed {
        instr_info_t           instr_info;
        aluop_t                aluop;
        alusel_t               alusel;
        logic                  reg_write_valid;
        reg_addr_t             reg_write_addr;
        logic                  csr_we;
        data_t                 oprand1;
        data_t                 oprand2;
        imm_u                  imm;
        logic [BR_FLAGS_W-1:0] branch_flags;
        csr_addr_t             csr_addr;
        data_t                 csr_data;
        logic                  excp;
        excp_num_t             excp_num;
        logic                  refetch;
    } dispatch_ex_t;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        data_t     data;
    } reg_wr_t;

    typedef struct packed {
        logic      we;
        csr_addr_t addr;
        data_t     data;
    } csr_wr_t;

endpackage

// ==== src/issue_ctrl.sv ====
`timescale 1ns/1ps

module issue_ctrl (
    input  pipe_if_pkg::id_dispatch_t [cpu_types_pkg::ISSUE_WIDTH-1:0] id_i,
    input  logic                                                       stall_i,
    output logic [cpu_types_pkg::ISSUE_WIDTH-1:0]                      issue_o,
    output logic [cpu_types_pkg::ISSUE_WIDTH-1:0]                      ib_accept_o,
    output cpu_types_pkg::csr_addr_t                                   csr_raddr_o
);

    import cpu_types_pkg::*;

    logic [ISSUE_WIDTH-1:0] issuable;
    logic [ISSUE_WIDTH-1:0] entry_valid;
    logic [1:0]             raw_hit;
    logic                   both_mem;
    csr_addr_t              csr_addr_or;

    // Lane 1 source against lane 0 destination
    always_comb begin
        for (int k = 0; k < 2; k++) begin
            raw_hit[k] = id_i[1].reg_read_valid[k] && id_i[0].reg_write_valid &&
                         (id_i[1].reg_read_addr[k] == id_i[0].reg_write_addr);
        end
    end

    // Only one memory port downstream
    assign both_mem = (id_i[0].alusel == RES_LOAD_STORE) &&
                      (id_i[1].alusel == RES_LOAD_STORE);

    always_comb begin
        issuable = '1;
        if (|raw_hit || both_mem) begin
            issuable[1] = 1'b0;
        end
    end

    always_comb begin
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            entry_valid[i] = id_i[i].instr_info.valid;
        end
    end

    assign issue_o     = issuable & entry_valid;
    assign ib_accept_o = stall_i ? '0 : issue_o;

    // At most one CSR instruction per pair, so the views can be merged
    always_comb begin
        csr_addr_or = '0;
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            csr_addr_or = csr_addr_or | id_i[i].imm.csr.addr;
        end
    end

    assign csr_raddr_o = csr_addr_or;

endmodule

// ==== src/regfile.sv ====
`timescale 1ns/1ps

module regfile (
    input  logic                                                       clk,
    input  logic                                                       rst_n,
    input  cpu_types_pkg::reg_addr_t [cpu_types_pkg::RF_RD_PORTS-1:0]  raddr_i,
    output cpu_types_pkg::data_t     [cpu_types_pkg::RF_RD_PORTS-1:0]  rdata_o,
    input  pipe_if_pkg::reg_wr_t     [cpu_types_pkg::RF_WR_PORTS-1:0]  wb_i
);

    import cpu_types_pkg::*;

    data_t regs [NUM_REGS];

    // Higher port index is applied last and wins on a shared address
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int w = 0; w < RF_WR_PORTS; w++) begin
                if (wb_i[w].we && wb_i[w].addr != '0) begin
                    regs[wb_i[w].addr] <= wb_i[w].data;
                end
            end
        end
    end

    // Old value during a write; forwarding covers the bypass
    always_comb begin
        for (int p = 0; p < RF_RD_PORTS; p++) begin
            if (raddr_i[p] == '0) begin
                rdata_o[p] = '0;
            end else begin
                rdata_o[p] = regs[raddr_i[p]];
            end
        end
    end

endmodule

// ==== src/csr_file.sv ====
`timescale 1ns/1ps

module csr_file (
    input  logic                      clk,
    input  logic                      rst_n,
    input  cpu_types_pkg::csr_addr_t  raddr_i,
    output cpu_types_pkg::data_t      rdata_o,
    input  pipe_if_pkg::csr_wr_t      wr_i
);

    import cpu_types_pkg::*;

    data_t                csrs [CSR_DEPTH];
    logic [CSR_IDX_W-1:0] rd_idx;
    logic [CSR_IDX_W-1:0] wr_idx;

    // Only the low address bits select a word
    assign rd_idx = raddr_i[CSR_IDX_W-1:0];
    assign wr_idx = wr_i.addr[CSR_IDX_W-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int c = 0; c < CSR_DEPTH; c++) begin
                csrs[c] <= '0;
            end
        end else if (wr_i.we) begin
            csrs[wr_idx] <= wr_i.data;
        end
    end

    assign rdata_o = csrs[rd_idx];

endmodule

// ==== dispatch/dispatch_lane.sv ====
`timescale 1ns/1ps

module dispatch_lane (
    input  logic                                                   clk,
    input  logic                                                   rst_n,
    input  logic                                                   flush_i,
    input  logic                                                   stall_i,
    input  logic                                                   issue_i,
    input  pipe_if_pkg::id_dispatch_t                              id_i,
    output cpu_types_pkg::reg_addr_t [1:0]                         rf_raddr_o,
    input  cpu_types_pkg::data_t     [1:0]                         rf_rdata_i,
    input  pipe_if_pkg::fwd_t [cpu_types_pkg::EXE_FWD_PORTS-1:0]   ex_fwd_i,
    input  pipe_if_pkg::fwd_t [cpu_types_pkg::MEM_FWD_PORTS-1:0]   mem_fwd_i,
    input  cpu_types_pkg::data_t                                   csr_rdata_i,
    output pipe_if_pkg::dispatch_ex_t                              exe_o
);

    import cpu_types_pkg::*;
    import pipe_if_pkg::*;

    data_t [1:0]            src_data;
    data_t                  oprand1;
    data_t                  oprand2;
    logic [BR_FLAGS_W-1:0]  br_flags;
    dispatch_ex_t           exe_d;

    // Priority chain: EXE 1, EXE 0, MEM 1, MEM 0, then regfile
    function automatic data_t fwd_select(
        input logic                          rd_valid,
        input reg_addr_t                     rd_addr,
        input data_t                         rf_data,
        input fwd_t [EXE_FWD_PORTS-1:0]      ex_fwd,
        input fwd_t [MEM_FWD_PORTS-1:0]      mem_fwd
    );
        data_t sel;
        logic  found;
        sel   = rf_data;
        found = 1'b0;
        for (int p = EXE_FWD_PORTS - 1; p >= 0; p--) begin
            if (!found && rd_valid && ex_fwd[p].valid && ex_fwd[p].addr == rd_addr) begin
                sel   = ex_fwd[p].data;
                found = 1'b1;
            end
        end
        for (int p = MEM_FWD_PORTS - 1; p >= 0; p--) begin
            if (!found && rd_valid && mem_fwd[p].valid && mem_fwd[p].addr == rd_addr) begin
                sel   = mem_fwd[p].data;
                found = 1'b1;
            end
        end
        return sel;
    endfunction

    assign rf_raddr_o = id_i.reg_read_addr;

    always_comb begin
        for (int k = 0; k < 2; k++) begin
            src_data[k] = fwd_select(id_i.reg_read_valid[k], id_i.reg_read_addr[k],
                                     rf_rdata_i[k], ex_fwd_i, mem_fwd_i);
        end
    end

    assign oprand1 = src_data[0];
    assign oprand2 = src_data[1];

    // Flags use the register operand even when an immediate replaces it
    always_comb begin
        br_flags[0] = (oprand1 == oprand2);
        br_flags[1] = (oprand1 != oprand2);
        br_flags[2] = ($signed(oprand1) <  $signed(oprand2));
        br_flags[3] = ($signed(oprand1) >= $signed(oprand2));
        br_flags[4] = (oprand1 <  oprand2);
        br_flags[5] = (oprand1 >= oprand2);
    end

    always_comb begin
        exe_d                 = '0;
        exe_d.instr_info      = id_i.instr_info;
        exe_d.aluop           = id_i.aluop;
        exe_d.alusel          = id_i.alusel;
        exe_d.reg_write_valid = id_i.reg_write_valid;
        exe_d.reg_write_addr  = id_i.reg_write_addr;
        exe_d.csr_we          = id_i.csr_we;
        exe_d.oprand1         = oprand1;
        exe_d.oprand2         = id_i.use_imm ? id_i.imm.value : oprand2;
        exe_d.imm             = id_i.imm;
        exe_d.branch_flags    = br_flags;
        exe_d.csr_addr        = id_i.imm.csr.addr;
        exe_d.csr_data        = csr_rdata_i;
        exe_d.excp            = id_i.excp;
        exe_d.excp_num        = id_i.excp_num;
        exe_d.refetch         = id_i.refetch;
    end

    // Flush beats stall; an unissued slot becomes a bubble
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exe_o <= '0;
        end else if (flush_i) begin
            exe_o <= '0;
        end else if (stall_i) begin
            exe_o <= exe_o;
        end else if (issue_i) begin
            exe_o <= exe_d;
        end else begin
            exe_o <= '0;
        end
    end

endmodule

// ==== src/dispatch_top.sv ====
`timescale 1ns/1ps

module dispatch_top (
    input  logic                                                          clk,
    input  logic                                                          rst_n,
    input  logic                                                          stall_i,
    input  logic                                                          flush_i,
    input  pipe_if_pkg::id_dispatch_t [cpu_types_pkg::ISSUE_WIDTH-1:0]    id_i,
    input  pipe_if_pkg::fwd_t         [cpu_types_pkg::EXE_FWD_PORTS-1:0]  ex_fwd_i,
    input  pipe_if_pkg::fwd_t         [cpu_types_pkg::MEM_FWD_PORTS-1:0]  mem_fwd_i,
    input  pipe_if_pkg::reg_wr_t      [cpu_types_pkg::RF_WR_PORTS-1:0]    wb_i,
    input  pipe_if_pkg::csr_wr_t                                          csr_wr_i,
    output logic                      [cpu_types_pkg::ISSUE_WIDTH-1:0]    ib_accept_o,
    output pipe_if_pkg::dispatch_ex_t [cpu_types_pkg::ISSUE_WIDTH-1:0]    exe_o
);

    import cpu_types_pkg::*;

    logic [ISSUE_WIDTH-1:0]    issue;
    csr_addr_t                 csr_raddr;
    data_t                     csr_rdata;
    reg_addr_t [RF_RD_PORTS-1:0] rf_raddr;
    data_t     [RF_RD_PORTS-1:0] rf_rdata;

    issue_ctrl u_issue_ctrl (
        .id_i        (id_i),
        .stall_i     (stall_i),
        .issue_o     (issue),
        .ib_accept_o (ib_accept_o),
        .csr_raddr_o (csr_raddr)
    );

    regfile u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .raddr_i (rf_raddr),
        .rdata_o (rf_rdata),
        .wb_i    (wb_i)
    );

    csr_file u_csr_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .raddr_i (csr_raddr),
        .rdata_o (csr_rdata),
        .wr_i    (csr_wr_i)
    );

    // Lane i owns regfile read ports 2i and 2i+1
    for (genvar i = 0; i < ISSUE_WIDTH; i++) begin : g_lane
        dispatch_lane u_lane (
            .clk         (clk),
            .rst_n       (rst_n),
            .flush_i     (flush_i),
            .stall_i     (stall_i),
            .issue_i     (issue[i]),
            .id_i        (id_i[i]),
            .rf_raddr_o  (rf_raddr[2*i+1:2*i]),
            .rf_rdata_i  (rf_rdata[2*i+1:2*i]),
            .ex_fwd_i    (ex_fwd_i),
            .mem_fwd_i   (mem_fwd_i),
            .csr_rdata_i (csr_rdata),
            .exe_o       (exe_o[i])
        );
    end

endmodule

// ==== bench/dispatch_chk.sv ====
`timescale 1ns/1ps

module dispatch_chk (
    input logic                                                       clk,
    input logic                                                       rst_n,
    input logic                                                       stall_i,
    input logic                                                       flush_i,
    input pipe_if_pkg::id_dispatch_t [cpu_types_pkg::ISSUE_WIDTH-1:0] id_i,
    input logic [cpu_types_pkg::ISSUE_WIDTH-1:0]                      ib_accept_o,
    input pipe_if_pkg::dispatch_ex_t [cpu_types_pkg::ISSUE_WIDTH-1:0] exe_o
);

    // Flush empties both lanes at the next edge
    a_flush_clears: assert property (@(posedge clk) disable iff (!rst_n)
        flush_i |=> exe_o == '0)
        else $error("exe_o not cleared after flush");

    a_stall_holds: assert property (@(posedge clk) disable iff (!rst_n)
        stall_i && !flush_i |=> exe_o == $past(exe_o))
        else $error("exe_o changed during stall");

    a_no_accept_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        stall_i |-> ib_accept_o == '0)
        else $error("instructions accepted while stalled");

    // Lane 1 never goes alone when both slots hold instructions
    a_in_order: assert property (@(posedge clk) disable iff (!rst_n)
        id_i[0].instr_info.valid && id_i[1].instr_info.valid && ib_accept_o[1]
        |-> ib_accept_o[0])
        else $error("lane 1 accepted without lane 0");

endmodule

bind dispatch_top dispatch_chk u_chk (
    .clk         (clk),
    .rst_n       (rst_n),
    .stall_i     (stall_i),
    .flush_i     (flush_i),
    .id_i        (id_i),
    .ib_accept_o (ib_accept_o),
    .exe_o       (exe_o)
);

// ==== bench/tb_dispatch_top.sv ====
`timescale 1ns/1ps

module tb_dispatch_top;

    import cpu_types_pkg::*;
    import pipe_if_pkg::*;

    localparam int NUM_CASES = 14;

    typedef struct packed {
        id_dispatch_t [ISSUE_WIDTH-1:0]   id;
        fwd_t         [EXE_FWD_PORTS-1:0] ex;
        fwd_t         [MEM_FWD_PORTS-1:0] mem;
        logic                             stall;
        logic                             flush;
        logic         [ISSUE_WIDTH-1:0]   acc;
    } case_t;

    logic                             clk;
    logic                             rst_n;
    logic                             stall_i;
    logic                             flush_i;
    id_dispatch_t [ISSUE_WIDTH-1:0]   id_i;
    fwd_t         [EXE_FWD_PORTS-1:0] ex_fwd_i;
    fwd_t         [MEM_FWD_PORTS-1:0] mem_fwd_i;
    reg_wr_t      [RF_WR_PORTS-1:0]   wb_i;
    csr_wr_t                          csr_wr_i;
    logic         [ISSUE_WIDTH-1:0]   ib_accept_o;
    dispatch_ex_t [ISSUE_WIDTH-1:0]   exe_o;

    case_t                            cases [NUM_CASES];
    data_t                            shadow_regs [NUM_REGS];
    data_t                            shadow_csrs [CSR_DEPTH];
    dispatch_ex_t [ISSUE_WIDTH-1:0]   exp_exe;
    logic [31:0]                      rng;
    int                               edge_count;
    int                               errors;
    int                               tests_run;
    int                               tests_failed;

    dispatch_top dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall_i     (stall_i),
        .flush_i     (flush_i),
        .id_i        (id_i),
        .ex_fwd_i    (ex_fwd_i),
        .mem_fwd_i   (mem_fwd_i),
        .wb_i        (wb_i),
        .csr_wr_i    (csr_wr_i),
        .ib_accept_o (ib_accept_o),
        .exe_o       (exe_o)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        edge_count <= edge_count + 1;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic data_t next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic id_dispatch_t mk_id(input logic v, input data_t pc, input alusel_t sel,
                                           input logic [1:0] rv, input reg_addr_t ra0,
                                           input reg_addr_t ra1, input logic wv,
                                           input reg_addr_t wa, input logic use_imm,
                                           input data_t imm);
        id_dispatch_t d;
        d                  = '0;
        d.instr_info.valid = v;
        d.instr_info.pc    = pc;
        d.aluop            = pc[9:2];
        d.alusel           = sel;
        d.reg_read_valid   = rv;
        d.reg_read_addr[0] = ra0;
        d.reg_read_addr[1] = ra1;
        d.reg_write_valid  = wv;
        d.reg_write_addr   = wa;
        d.use_imm          = use_imm;
        d.imm.value        = imm;
        d.excp             = pc[3];
        d.excp_num         = pc[7:2];
        d.refetch          = pc[2];
        return d;
    endfunction

    function automatic fwd_t mk_fwd(input logic v, input reg_addr_t a);
        fwd_t f;
        f.valid = v;
        f.addr  = a;
        f.data  = next_rand();
        return f;
    endfunction

    // EXE 1, EXE 0, MEM 1, MEM 0, else the register file
    function automatic data_t ref_operand(input logic rv, input reg_addr_t a,
                                          input case_t c);
        data_t val;
        val = (a == 0) ? '0 : shadow_regs[a];
        if (rv && c.ex[1].valid && c.ex[1].addr == a) val = c.ex[1].data;
        else if (rv && c.ex[0].valid && c.ex[0].addr == a) val = c.ex[0].data;
        else if (rv && c.mem[1].valid && c.mem[1].addr == a) val = c.mem[1].data;
        else if (rv && c.mem[0].valid && c.mem[0].addr == a) val = c.mem[0].data;
        return val;
    endfunction

    function automatic dispatch_ex_t ref_lane(input case_t c, input int l,
                                              input dispatch_ex_t prev);
        dispatch_ex_t r;
        data_t        a;
        data_t        b;
        csr_addr_t    craddr;
        r = '0;
        if (c.flush) return '0;
        if (c.stall) return prev;
        if (!c.acc[l]) return '0;
        a      = ref_operand(c.id[l].reg_read_valid[0], c.id[l].reg_read_addr[0], c);
        b      = ref_operand(c.id[l].reg_read_valid[1], c.id[l].reg_read_addr[1], c);
        craddr = c.id[0].imm.value[13:0] | c.id[1].imm.value[13:0];
        r.instr_info      = c.id[l].instr_info;
        r.aluop           = c.id[l].aluop;
        r.alusel          = c.id[l].alusel;
        r.reg_write_valid = c.id[l].reg_write_valid;
        r.reg_write_addr  = c.id[l].reg_write_addr;
        r.csr_we          = c.id[l].csr_we;
        r.oprand1         = a;
        r.oprand2         = c.id[l].use_imm ? c.id[l].imm.value : b;
        r.imm             = c.id[l].imm;
        r.branch_flags    = {a >= b, a < b, $signed(a) >= $signed(b),
                             $signed(a) < $signed(b), a != b, a == b};
        r.csr_addr        = c.id[l].imm.value[13:0];
        r.csr_data        = shadow_csrs[craddr[3:0]];
        r.excp            = c.id[l].excp;
        r.excp_num        = c.id[l].excp_num;
        r.refetch         = c.id[l].refetch;
        return r;
    endfunction

    task automatic check_accept(input logic [ISSUE_WIDTH-1:0] got,
                                input logic [ISSUE_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: accept mask %b, expected %b", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_lane(input dispatch_ex_t got, input dispatch_ex_t exp, input int l);
        if (got !== exp) begin
            $display("[ERROR] %0t: lane %0d got %h expected %h", $time, l, got, exp);
            errors++;
        end
    endtask

    // Polls on odd times only, so it never lands on a clock edge
    task automatic step_cycle();
        int target;
        int guard;
        target = edge_count + 1;
        guard  = 0;
        while (edge_count < target && guard < 50) begin
            #2;
            guard++;
        end
        if (edge_count < target) begin
            $display("Timeout: no rising clock edge seen");
            $display("Result: FAILED");
            $finish;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (errors != errs_before) tests_failed++;
        $display("test %s: %s", name, (errors == errs_before) ? "ok" : "mismatch");
    endtask

    task automatic build_cases();
        for (int i = 0; i < NUM_CASES; i++) cases[i] = '0;
        cases[0].id[0]  = mk_id(1, 32'h100, RES_ARITH, 2'b11, 1, 2, 1, 3, 0, 0);
        cases[0].id[1]  = mk_id(1, 32'h104, RES_LOGIC, 2'b11, 4, 5, 1, 6, 0, 0);
        cases[1].id[0]  = mk_id(1, 32'h108, RES_ARITH, 2'b11, 0, 7, 1, 20, 1, 32'h123);
        cases[1].id[1]  = mk_id(1, 32'h10c, RES_BRANCH, 2'b11, 8, 0, 0, 0, 0, 0);
        cases[2].id[0]  = mk_id(1, 32'h110, RES_ARITH, 2'b11, 1, 2, 1, 9, 0, 0);
        cases[2].id[1]  = mk_id(1, 32'h114, RES_ARITH, 2'b11, 9, 1, 1, 4, 0, 0);
        cases[3].id[0]  = cases[2].id[0];
        cases[3].id[1]  = mk_id(1, 32'h118, RES_LOGIC, 2'b11, 2, 9, 1, 5, 0, 0);
        cases[4].id[0]  = mk_id(1, 32'h11c, RES_LOAD_STORE, 2'b01, 1, 0, 1, 10, 1, 32'h8);
        cases[4].id[1]  = mk_id(1, 32'h120, RES_LOAD_STORE, 2'b11, 2, 3, 0, 0, 1, 32'h10);
        cases[5].id[0]  = mk_id(0, 32'h124, RES_ARITH, 2'b11, 1, 2, 1, 3, 0, 0);
        cases[5].id[1]  = mk_id(1, 32'h128, RES_ARITH, 2'b11, 5, 6, 1, 7, 0, 0);
        // Several ports hit the same register at once
        cases[6].id[0]  = mk_id(1, 32'h12c, RES_ARITH, 2'b11, 10, 11, 1, 12, 0, 0);
        cases[6].id[1]  = mk_id(1, 32'h130, RES_ARITH, 2'b01, 11, 10, 1, 15, 0, 0);
        cases[6].ex[1]  = mk_fwd(1, 10);
        cases[6].ex[0]  = mk_fwd(1, 10);
        cases[6].mem[1] = mk_fwd(1, 11);
        cases[6].mem[0] = mk_fwd(1, 11);
        cases[7].id[0]  = mk_id(1, 32'h134, RES_ARITH, 2'b11, 10, 11, 1, 12, 0, 0);
        cases[7].id[1]  = mk_id(1, 32'h138, RES_BRANCH, 2'b11, 11, 10, 0, 0, 0, 0);
        cases[7].ex[1]  = mk_fwd(0, 10);
        cases[7].ex[0]  = mk_fwd(1, 11);
        cases[7].mem[1] = mk_fwd(1, 10);
        cases[7].mem[0] = mk_fwd(1, 11);
        cases[8].id[0]  = mk_id(1, 32'h13c, RES_CSR, 2'b01, 3, 0, 1, 13, 0, 32'h2105);
        cases[8].id[0].csr_we = 1'b1;
        cases[8].id[1]  = mk_id(1, 32'h140, RES_ARITH, 2'b11, 4, 5, 1, 14, 0, 0);
        cases[9].id[0]  = mk_id(1, 32'h144, RES_LOGIC, 2'b11, 6, 7, 1, 16, 0, 0);
        cases[9].id[1]  = mk_id(1, 32'h148, RES_CSR, 2'b00, 0, 0, 1, 17, 0, 32'h000c);
        // MEM 0 as the only matching port
        cases[9].mem[0] = mk_fwd(1, 7);
        cases[10].id[0] = cases[0].id[0];
        cases[10].id[1] = cases[0].id[1];
        cases[10].stall = 1'b1;
        cases[11].id    = cases[0].id;
        cases[11].flush = 1'b1;
        cases[12].id[0] = mk_id(1, 32'h14c, RES_ARITH, 2'b11, 17, 18, 1, 21, 1, 32'hffff_fffb);
        cases[12].id[1] = mk_id(1, 32'h150, RES_BRANCH, 2'b11, 19, 17, 0, 0, 0, 0);
        cases[13].id    = cases[12].id;
        cases[13].stall = 1'b1;
        cases[13].flush = 1'b1;
        for (int i = 0; i < NUM_CASES; i++) begin
            cases[i].acc = cases[i].stall ? 2'b00 :
                           (i == 2 || i == 3 || i == 4) ? 2'b01 :
                           (i == 5) ? 2'b10 : 2'b11;
        end
    endtask

    initial begin
        int    errs_before;
        data_t hi_bits;
        clk = 0;
        rst_n = 0;
        stall_i = 0;
        flush_i = 0;
        id_i = '0;
        ex_fwd_i = '0;
        mem_fwd_i = '0;
        wb_i = '0;
        csr_wr_i = '0;
        edge_count = 0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        exp_exe = '0;
        rng = 32'hd096_195a;
        for (int r = 0; r < NUM_REGS; r++) shadow_regs[r] = '0;
        for (int c = 0; c < CSR_DEPTH; c++) shadow_csrs[c] = '0;
        #1;
        step_cycle();
        step_cycle();
        rst_n = 1;
        errs_before = errors;
        for (int l = 0; l < ISSUE_WIDTH; l++) check_lane(exe_o[l], '0, l);
        finish_test("reset", errs_before);

        // Fill registers, one write port per cycle, then the CSRs
        for (int r = 1; r < NUM_REGS; r++) begin
            wb_i = '0;
            wb_i[r % 2] = '{we: 1'b1, addr: reg_addr_t'(r), data: next_rand()};
            shadow_regs[r] = wb_i[r % 2].data;
            step_cycle();
        end
        // Both ports on one register, port 1 must win
        wb_i[0] = '{we: 1'b1, addr: 5'd5, data: next_rand()};
        wb_i[1] = '{we: 1'b1, addr: 5'd5, data: next_rand()};
        shadow_regs[5] = wb_i[1].data;
        step_cycle();
        wb_i = '0;
        for (int c = 0; c < CSR_DEPTH; c++) begin
            hi_bits = next_rand();
            csr_wr_i = '{we: 1'b1, addr: {hi_bits[9:0], 4'(c)}, data: next_rand()};
            shadow_csrs[c] = csr_wr_i.data;
            step_cycle();
        end
        csr_wr_i = '0;

        build_cases();
        for (int t = 0; t < NUM_CASES; t++) begin
            errs_before = errors;
            id_i      = cases[t].id;
            ex_fwd_i  = cases[t].ex;
            mem_fwd_i = cases[t].mem;
            stall_i   = cases[t].stall;
            flush_i   = cases[t].flush;
            for (int l = 0; l < ISSUE_WIDTH; l++) begin
                exp_exe[l] = ref_lane(cases[t], l, exp_exe[l]);
            end
            #2;
            check_accept(ib_accept_o, cases[t].acc);
            step_cycle();
            for (int l = 0; l < ISSUE_WIDTH; l++) check_lane(exe_o[l], exp_exe[l], l);
            finish_test($sformatf("row %0d", t), errs_before);
        end
        stall_i = 0;
        flush_i = 0;
        id_i = '0;

        $display("tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== dispatch_top.f ====
common/cpu_types_pkg.sv
common/pipe_if_pkg.sv
src/issue_ctrl.sv
src/regfile.sv
src/csr_file.sv
dispatch/dispatch_lane.sv
src/dispatch_top.sv
bench/dispatch_chk.sv
bench/tb_dispatch_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the dispatch testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module tb_dispatch_top \
    -f dispatch_top.f -o tb_sim > build.log 2>&1 &&
    ./obj_dir/tb_sim > sim.log 2>&1 ||
    echo "build or simulation did not complete, see build.log and sim.log"

grep -q "^Result: PASSED$" sim.log 2>/dev/null &&
    echo "simulation passed" && exit 0 ||
    { echo "simulation failed"; exit 1; }
